// File: design/core_cfg_pkg.sv
package core_cfg_pkg;

    // Operations renamed per cycle
    localparam int rename_width = 2;

    localparam int arch_regs = 32;
    localparam int phys_regs = 64;

    localparam int preg_w = $clog2(phys_regs);
    localparam int areg_w = $clog2(arch_regs);

    // ROB depth must stay a power of two, the wrap is taken from the carry
    localparam int rob_depth = 32;
    localparam int rob_w = $clog2(rob_depth);

    // A count of slots, 0 up to rename_width
    localparam int cnt_w = $clog2(rename_width + 1);

    // Index of a slot inside the group
    localparam int slot_w = (rename_width > 1) ? $clog2(rename_width) : 1;

    // Registers not held by the reset mapping start out free
    localparam int fl_depth = phys_regs - arch_regs;
    localparam int fl_w = $clog2(fl_depth);

endpackage

// File: design/rename_types_pkg.sv
package rename_types_pkg;

    import core_cfg_pkg::*;

    typedef logic [areg_w-1:0] areg_t;
    typedef logic [preg_w-1:0] preg_t;
    typedef logic [slot_w-1:0] slot_t;

    // The dir bit flips each time the index wraps past rob_depth-1
    typedef struct packed {
        logic             dir;
        logic [rob_w-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic       en;
        logic       we;
        areg_t      rs1;
        areg_t      rs2;
        areg_t      rd;
        logic [7:0] tag;  // Opaque, carried through unchanged
    } dec_op_t;

    typedef struct packed {
        dec_op_t  op;
        preg_t    prs1;
        preg_t    prs2;
        preg_t    prd;
        preg_t    old_prd;  // Mapping of rd before this op, freed at its commit
        rob_idx_t rob_idx;
    } ren_op_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        areg_t rd;
        preg_t prd;
        preg_t old_prd;
    } commit_t;

    typedef dec_op_t [rename_width-1:0] dec_group_t;
    typedef ren_op_t [rename_width-1:0] ren_group_t;
    typedef commit_t [rename_width-1:0] commit_group_t;

endpackage

// File: design/rename_table.sv
`timescale 1ns/1ns

module rename_table (
    input  logic                                                clk,
    input  logic                                                rst,
    input  rename_types_pkg::areg_t [core_cfg_pkg::rename_width-1:0] rs1_idx,
    input  rename_types_pkg::areg_t [core_cfg_pkg::rename_width-1:0] rs2_idx,
    input  rename_types_pkg::areg_t [core_cfg_pkg::rename_width-1:0] rd_idx,
    output rename_types_pkg::preg_t [core_cfg_pkg::rename_width-1:0] prs1,
    output rename_types_pkg::preg_t [core_cfg_pkg::rename_width-1:0] prs2,
    output rename_types_pkg::preg_t [core_cfg_pkg::rename_width-1:0] prev_prd,
    input  logic [core_cfg_pkg::rename_width-1:0]               ren_we,
    input  rename_types_pkg::areg_t [core_cfg_pkg::rename_width-1:0] ren_rd,
    input  rename_types_pkg::preg_t [core_cfg_pkg::rename_width-1:0] ren_prd,
    input  rename_types_pkg::commit_group_t                     commit,
    input  logic                                                redirect
);

    import core_cfg_pkg::*;
    import rename_types_pkg::*;

    preg_t spec_map [arch_regs];
    preg_t arch_map [arch_regs];
    preg_t arch_next [arch_regs];  // Architectural map after this cycle's commits

    // Commits apply in slot order so a younger slot wins on the same rd
    always_comb begin
        arch_next = arch_map;
        for (int i = 0; i < rename_width; i++) begin
            if (commit[i].valid && commit[i].we && commit[i].rd != '0) begin
                arch_next[commit[i].rd] = commit[i].prd;
            end
        end
    end

    for (genvar i = 0; i < rename_width; i++) begin : g_lookup
        assign prs1[i]     = spec_map[rs1_idx[i]];
        assign prs2[i]     = spec_map[rs2_idx[i]];
        assign prev_prd[i] = spec_map[rd_idx[i]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < arch_regs; i++) begin
                spec_map[i] <= preg_t'(i);
                arch_map[i] <= preg_t'(i);
            end
        end else begin
            arch_map <= arch_next;
            if (redirect) begin
                spec_map <= arch_next;  // Drops every rename still in flight
            end else begin
                // The stage only enables the last writer of each rd
                for (int i = 0; i < rename_width; i++) begin
                    if (ren_we[i]) begin
                        spec_map[ren_rd[i]] <= ren_prd[i];
                    end
                end
            end
        end
    end

endmodule

// File: design/free_list.sv
`timescale 1ns/1ns

module free_list (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [core_cfg_pkg::cnt_w-1:0]                       pop_num,
    output rename_types_pkg::preg_t [core_cfg_pkg::rename_width-1:0] free_prd,
    output logic [core_cfg_pkg::fl_w:0]                          avail,
    input  rename_types_pkg::commit_group_t                      commit,
    input  logic                                                 redirect
);

    import core_cfg_pkg::*;
    import rename_types_pkg::*;

    preg_t mem [fl_depth];

    // Pointers carry one extra bit so that full and empty differ
    logic [fl_w:0] head;    // Speculative read pointer
    logic [fl_w:0] c_head;  // Read pointer as of the last commit
    logic [fl_w:0] tail;
    logic [fl_w:0] c_head_next;
    logic [fl_w:0] tail_next;
    logic [fl_w:0] push_pos [rename_width];
    logic [rename_width-1:0] push_en;

    // Every committed write frees its old register and retires one pop
    always_comb begin
        c_head_next = c_head;
        tail_next   = tail;
        for (int i = 0; i < rename_width; i++) begin
            push_en[i]  = commit[i].valid && commit[i].we && commit[i].rd != '0;
            push_pos[i] = tail_next;
            if (push_en[i]) begin
                tail_next   = tail_next + 1'b1;
                c_head_next = c_head_next + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < rename_width; i++) begin : g_peek
        assign free_prd[i] = mem[head[fl_w-1:0] + fl_w'(i)];
    end

    assign avail = tail - head;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fl_depth; i++) begin
                mem[i] <= preg_t'(arch_regs + i);
            end
            head   <= '0;
            c_head <= '0;
            tail   <= (fl_w + 1)'(fl_depth);
        end else begin
            for (int i = 0; i < rename_width; i++) begin
                if (push_en[i]) begin
                    mem[push_pos[i][fl_w-1:0]] <= commit[i].old_prd;
                end
            end
            c_head <= c_head_next;
            tail   <= tail_next;
            if (redirect) begin
                head <= c_head_next;  // Includes commits taken at this same edge
            end else begin
                head <= head + (fl_w + 1)'(pop_num);
            end
        end
    end

endmodule

// File: design/dep_check.sv
`timescale 1ns/1ns

module dep_check (
    input  logic [core_cfg_pkg::rename_width-1:0]                    wr,
    input  rename_types_pkg::areg_t [core_cfg_pkg::rename_width-1:0] rs1,
    input  rename_types_pkg::areg_t [core_cfg_pkg::rename_width-1:0] rs2,
    input  rename_types_pkg::areg_t [core_cfg_pkg::rename_width-1:0] rd,
    output logic [core_cfg_pkg::rename_width-1:0]                    raw1_hit,
    output logic [core_cfg_pkg::rename_width-1:0]                    raw2_hit,
    output logic [core_cfg_pkg::rename_width-1:0]                    waw_hit,
    output rename_types_pkg::slot_t [core_cfg_pkg::rename_width-1:0] raw1_src,
    output rename_types_pkg::slot_t [core_cfg_pkg::rename_width-1:0] raw2_src,
    output rename_types_pkg::slot_t [core_cfg_pkg::rename_width-1:0] waw_src
);

    import core_cfg_pkg::*;
    import rename_types_pkg::*;

    // Sources look back at older writers, ascending so the youngest match is kept
    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            raw1_hit[i] = 1'b0;
            raw2_hit[i] = 1'b0;
            raw1_src[i] = '0;
            raw2_src[i] = '0;
            for (int j = 0; j < i; j++) begin
                if (wr[j] && rs1[i] == rd[j]) begin
                    raw1_hit[i] = 1'b1;
                    raw1_src[i] = slot_t'(j);
                end
                if (wr[j] && rs2[i] == rd[j]) begin
                    raw2_hit[i] = 1'b1;
                    raw2_src[i] = slot_t'(j);
                end
            end
        end
    end

    // A writer whose rd is rewritten later in the group; waw_src is the
    // nearest such later slot, which takes this slot's prd as its old_prd
    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            waw_hit[i] = 1'b0;
            waw_src[i] = '0;
            for (int j = rename_width - 1; j > i; j--) begin
                if (wr[i] && wr[j] && rd[i] == rd[j]) begin
                    waw_hit[i] = 1'b1;
                    waw_src[i] = slot_t'(j);
                end
            end
        end
    end

endmodule

// File: design/rename_stage.sv
`timescale 1ns/1ns

module rename_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_valid,
    input  rename_types_pkg::dec_group_t        in_group,
    output logic                                in_ready,
    output logic                                out_valid,
    output rename_types_pkg::ren_group_t        out_group,
    input  logic                                dis_stall,
    input  rename_types_pkg::rob_idx_t          rob_tail,
    output logic [core_cfg_pkg::cnt_w-1:0]      alloc_num,
    input  rename_types_pkg::commit_group_t     commit,
    input  logic                                redirect
);

    import core_cfg_pkg::*;
    import rename_types_pkg::*;

    logic [rename_width-1:0] en;
    logic [rename_width-1:0] wr;      // Slot really writes a register
    logic [rename_width-1:0] ren_we;
    areg_t [rename_width-1:0] rs1;
    areg_t [rename_width-1:0] rs2;
    areg_t [rename_width-1:0] rd;
    preg_t [rename_width-1:0] tbl_prs1;
    preg_t [rename_width-1:0] tbl_prs2;
    preg_t [rename_width-1:0] tbl_prev;
    preg_t [rename_width-1:0] free_prd;
    preg_t [rename_width-1:0] prd;
    slot_t [rename_width-1:0] fl_off;
    logic [rename_width-1:0] raw1_hit;
    logic [rename_width-1:0] raw2_hit;
    logic [rename_width-1:0] waw_hit;
    slot_t [rename_width-1:0] raw1_src;
    slot_t [rename_width-1:0] raw2_src;
    slot_t [rename_width-1:0] waw_src;
    logic [fl_w:0] avail;
    logic [cnt_w-1:0] wr_num;
    logic [cnt_w-1:0] en_num;
    logic [cnt_w-1:0] alloc_num_wr;
    logic [rob_w:0] rob_sum [rename_width];
    logic accept;
    ren_group_t ren_group;

    for (genvar i = 0; i < rename_width; i++) begin : g_slot
        assign en[i]      = in_group[i].en;
        assign wr[i]      = in_group[i].en && in_group[i].we && in_group[i].rd != '0;
        assign rs1[i]     = in_group[i].rs1;
        assign rs2[i]     = in_group[i].rs2;
        assign rd[i]      = in_group[i].rd;
        assign prd[i]     = wr[i] ? free_prd[fl_off[i]] : '0;
        assign ren_we[i]  = accept && wr[i] && !waw_hit[i];
        assign rob_sum[i] = {1'b0, rob_tail.idx} + (rob_w + 1)'(i);  // Top bit is the wrap
    end

    // Writers take free-list entries in slot order
    always_comb begin
        wr_num = '0;
        en_num = '0;
        for (int i = 0; i < rename_width; i++) begin
            fl_off[i] = slot_t'(wr_num);
            wr_num    = wr_num + cnt_w'(wr[i]);
            en_num    = en_num + cnt_w'(en[i]);
        end
    end

    assign in_ready     = !dis_stall && !redirect && (avail >= (fl_w + 1)'(wr_num));
    assign accept       = in_valid && in_ready;
    assign alloc_num_wr = accept ? wr_num : '0;
    assign alloc_num    = accept ? en_num : '0;

    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            ren_group[i].op   = in_group[i];
            ren_group[i].prs1 = raw1_hit[i] ? prd[raw1_src[i]] : tbl_prs1[i];
            ren_group[i].prs2 = raw2_hit[i] ? prd[raw2_src[i]] : tbl_prs2[i];
            ren_group[i].prd  = prd[i];
            ren_group[i].old_prd = wr[i] ? tbl_prev[i] : '0;
            for (int j = 0; j < i; j++) begin
                if (waw_hit[j] && waw_src[j] == slot_t'(i)) begin
                    ren_group[i].old_prd = prd[j];  // Previous writer sits in this group
                end
            end
            ren_group[i].rob_idx.idx = rob_sum[i][rob_w-1:0];
            ren_group[i].rob_idx.dir = rob_tail.dir ^ rob_sum[i][rob_w];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            out_valid <= 1'b0;
        end else if (!dis_stall) begin
            out_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_group <= ren_group;
        end
    end

    rename_table rename_table_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_idx  (rs1),
        .rs2_idx  (rs2),
        .rd_idx   (rd),
        .prs1     (tbl_prs1),
        .prs2     (tbl_prs2),
        .prev_prd (tbl_prev),
        .ren_we   (ren_we),
        .ren_rd   (rd),
        .ren_prd  (prd),
        .commit   (commit),
        .redirect (redirect)
    );

    free_list free_list_i (
        .clk      (clk),
        .rst      (rst),
        .pop_num  (alloc_num_wr),
        .free_prd (free_prd),
        .avail    (avail),
        .commit   (commit),
        .redirect (redirect)
    );

    dep_check dep_check_i (
        .wr       (wr),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .raw1_hit (raw1_hit),
        .raw2_hit (raw2_hit),
        .waw_hit  (waw_hit),
        .raw1_src (raw1_src),
        .raw2_src (raw2_src),
        .waw_src  (waw_src)
    );

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset covers the first four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: bench/rename_chk.sv
`timescale 1ns/1ns

module rename_chk (
    input logic                              clk,
    input logic                              rst,
    input logic                              in_ready,
    input logic                              out_valid,
    input rename_types_pkg::ren_group_t      out_group,
    input logic                              dis_stall,
    input logic                              redirect,
    input logic [core_cfg_pkg::cnt_w-1:0]    alloc_num,
    input logic                              exp_ready,
    input logic                              exp_valid,
    input rename_types_pkg::ren_group_t      exp_group,
    input logic [core_cfg_pkg::cnt_w-1:0]    exp_alloc
);

    import core_cfg_pkg::*;
    import rename_types_pkg::*;

    int fail_cnt = 0;

    function automatic logic is_writer(input ren_op_t o);
        return o.op.en && o.op.we && o.op.rd != '0;
    endfunction

    ready_a: assert property (@(posedge clk) disable iff (rst) in_ready == exp_ready)
        else begin
            $error("[FAIL] in_ready exp %h got %h", $sampled(exp_ready), $sampled(in_ready));
            fail_cnt++;
        end

    alloc_a: assert property (@(posedge clk) disable iff (rst) alloc_num == exp_alloc)
        else begin
            $error("[FAIL] alloc_num exp %h got %h", $sampled(exp_alloc), $sampled(alloc_num));
            fail_cnt++;
        end

    valid_a: assert property (@(posedge clk) disable iff (rst) out_valid == exp_valid)
        else begin
            $error("[FAIL] out_valid exp %h got %h", $sampled(exp_valid), $sampled(out_valid));
            fail_cnt++;
        end

    group_a: assert property (@(posedge clk) disable iff (rst) out_valid |-> out_group == exp_group)
        else begin
            $error("[FAIL] out_group exp %h got %h", $sampled(exp_group), $sampled(out_group));
            fail_cnt++;
        end

    // A stalled output keeps both its valid and its payload
    hold_a: assert property (@(posedge clk) disable iff (rst)
        out_valid && dis_stall && !redirect |=> out_valid && $stable(out_group))
        else begin
            $error("Output changed while dispatch was stalled");
            fail_cnt++;
        end

    flush_a: assert property (@(posedge clk) disable iff (rst) redirect |=> !out_valid)
        else begin
            $error("Output still valid in the cycle after a redirect");
            fail_cnt++;
        end

    for (genvar i = 1; i < rename_width; i++) begin : g_slot
        rob_a: assert property (@(posedge clk) disable iff (rst)
            out_valid |-> out_group[i].rob_idx == rob_idx_t'(out_group[i-1].rob_idx + 1'b1))
            else begin
                $error("[FAIL] out_group[%0d].rob_idx exp %h got %h", i,
                       rob_idx_t'($sampled(out_group[i-1].rob_idx) + 1'b1),
                       $sampled(out_group[i].rob_idx));
                fail_cnt++;
            end

        prd_a: assert property (@(posedge clk) disable iff (rst)
            out_valid && is_writer(out_group[i]) && is_writer(out_group[i-1])
            |-> out_group[i].prd != out_group[i-1].prd)
            else begin
                $error("Two slots of one group got the same physical register");
                fail_cnt++;
            end
    end

endmodule

// File: bench/rename_tb.sv
`timescale 1ns/1ns

module rename_tb;

    import core_cfg_pkg::*;
    import rename_types_pkg::*;

    // Groups per phase for independent, RAW, WAW pairs, x0, stall, starved list and redirects
    localparam int n_groups = 24 + 10 + 2 * 8 + 10 + 6 + 20 + 2 * 10;
    localparam int cycle_limit = n_groups * 4 + 200;

    logic clk;
    logic rst;
    logic in_valid = 1'b0;
    dec_group_t in_group = '0;
    logic in_ready;
    logic out_valid;
    ren_group_t out_group;
    logic dis_stall = 1'b0;
    rob_idx_t rob_tail = '0;
    logic [cnt_w-1:0] alloc_num;
    commit_group_t commit = '0;
    logic redirect = 1'b0;

    preg_t spec_map [arch_regs];
    preg_t arch_map [arch_regs];
    preg_t free_q [$];      // Starts at the committed head
    int spec_pops = 0;      // Entries handed out past the committed head
    ren_op_t inflight [$];  // Renamed ops waiting to commit
    int fl_avail = 0;
    logic commit_en = 1'b0;
    logic exp_ready;
    logic exp_valid = 1'b0;
    ren_group_t exp_group;
    logic [cnt_w-1:0] exp_alloc;
    logic [7:0] next_tag = '0;
    int reached [5] = '{0, 0, 0, 0, 0};
    string behavior [5] = '{"ROB index wrap", "in-group RAW bypass", "in-group WAW",
                            "stall on a short free list", "redirect"};
    int cycles = 0;
    int tb_errors = 0;

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    rename_stage rename_stage_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_group  (in_group),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_group (out_group),
        .dis_stall (dis_stall),
        .rob_tail  (rob_tail),
        .alloc_num (alloc_num),
        .commit    (commit),
        .redirect  (redirect)
    );

    bind rename_stage rename_chk chk_i (
        .clk(clk), .rst(rst), .in_ready(in_ready), .out_valid(out_valid),
        .out_group(out_group), .dis_stall(dis_stall), .redirect(redirect),
        .alloc_num(alloc_num), .exp_ready(rename_tb.exp_ready),
        .exp_valid(rename_tb.exp_valid), .exp_group(rename_tb.exp_group),
        .exp_alloc(rename_tb.exp_alloc)
    );

    function automatic int count_slots(input dec_group_t g, input bit writes_only);
        int n;
        n = 0;
        for (int i = 0; i < rename_width; i++) begin
            n += int'(g[i].en && (!writes_only || (g[i].we && g[i].rd != '0)));
        end
        return n;
    endfunction

    assign exp_ready = !dis_stall && !redirect && fl_avail >= count_slots(in_group, 1'b1);
    assign exp_alloc = (in_valid && exp_ready) ? cnt_w'(count_slots(in_group, 1'b0)) : '0;

    // Slots are renamed one after another, so a later slot sees an earlier slot's write
    function automatic ren_group_t rename_group(input dec_group_t g);
        ren_group_t r;
        int sum;
        for (int i = 0; i < rename_width; i++) begin
            r[i].op      = g[i];
            r[i].prs1    = spec_map[g[i].rs1];
            r[i].prs2    = spec_map[g[i].rs2];
            r[i].prd     = '0;
            r[i].old_prd = '0;
            if (g[i].en && g[i].we && g[i].rd != '0) begin
                r[i].prd = free_q[spec_pops];
                r[i].old_prd = spec_map[g[i].rd];
                spec_map[g[i].rd] = r[i].prd;
                spec_pops++;
            end
            sum = int'(rob_tail.idx) + i;
            r[i].rob_idx.idx = rob_w'(sum % rob_depth);
            r[i].rob_idx.dir = rob_tail.dir ^ (sum >= rob_depth);
        end
        return r;
    endfunction

    // Kind 0 independent, 1 RAW, 2 WAW, 3 x0 writes and disabled slots
    function automatic dec_group_t make_group(input int kind);
        dec_group_t g;
        for (int i = 0; i < rename_width; i++) begin
            g[i].en  = 1'b1;
            g[i].we  = 1'b1;
            g[i].rs1 = areg_t'($urandom);
            g[i].rs2 = areg_t'($urandom);
            g[i].rd  = areg_t'($urandom_range(1, arch_regs - 1));
            g[i].tag = next_tag + 8'(i);
        end
        next_tag += 8'(rename_width);
        case (kind)
            0: if (g[1].rd == g[0].rd) g[1].rd = (g[0].rd == '1) ? areg_t'(1) : g[0].rd + 1'b1;
            1: g[1].rs1 = g[0].rd;
            2: g[1].rd = g[0].rd;
            default: begin
                g[$urandom_range(0, rename_width - 1)].rd = '0;
                g[$urandom_range(0, rename_width - 1)].en = 1'($urandom_range(0, 1));
                g[0].we = 1'($urandom_range(0, 1));
            end
        endcase
        return g;
    endfunction

    task automatic send_group(input dec_group_t g);
        in_valid <= 1'b1;
        in_group <= g;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic hold_output(input int n);
        dis_stall <= 1'b1;
        repeat (n) @(posedge clk);
        dis_stall <= 1'b0;
    endtask

    // Shadow model and commit driver work on values sampled before the edge
    always @(posedge clk) begin
        ren_group_t r;
        commit_group_t c;
        ren_op_t op;
        int n;
        if (rst) begin
            for (int i = 0; i < arch_regs; i++) begin
                spec_map[i] = preg_t'(i);
                arch_map[i] = preg_t'(i);
            end
            free_q.delete();
            for (int i = arch_regs; i < phys_regs; i++) begin
                free_q.push_back(preg_t'(i));
            end
            spec_pops = 0;
            inflight.delete();
            exp_valid <= 1'b0;
            commit <= '0;
            rob_tail <= '0;
        end else begin
            if (in_valid && exp_ready) begin
                r = rename_group(in_group);
                exp_group <= r;
                rob_tail <= rob_idx_t'(rob_tail + exp_alloc);  // The ROB takes the group
                for (int i = 0; i < rename_width; i++) begin
                    if (in_group[i].en) inflight.push_back(r[i]);
                    reached[0] += int'(r[i].rob_idx.idx == '0 && r[i].rob_idx.dir);
                end
                reached[1] += int'(r[0].prd != '0 && r[1].prs1 == r[0].prd);
                reached[2] += int'(r[0].prd != '0 && r[1].old_prd == r[0].prd);
            end
            if (redirect) begin
                exp_valid <= 1'b0;
            end else if (!dis_stall) begin
                exp_valid <= in_valid && exp_ready;
            end
            reached[3] += int'(in_valid && !exp_ready && !dis_stall && !redirect);
            for (int i = 0; i < rename_width; i++) begin
                if (commit[i].valid && commit[i].we && commit[i].rd != '0) begin
                    arch_map[commit[i].rd] = commit[i].prd;
                    free_q.push_back(commit[i].old_prd);
                    void'(free_q.pop_front());
                    spec_pops--;
                end
            end
            if (redirect) begin
                spec_map = arch_map;
                spec_pops = 0;
                inflight.delete();
                reached[4]++;
            end
            c = '0;
            n = commit_en ? $urandom_range(0, rename_width) : 0;
            for (int i = 0; i < n && inflight.size() > 0; i++) begin
                op = inflight.pop_front();
                c[i].valid   = 1'b1;
                c[i].we      = op.op.we;
                c[i].rd      = op.op.rd;
                c[i].prd     = op.prd;
                c[i].old_prd = op.old_prd;
            end
            commit <= c;
        end
        fl_avail <= free_q.size() - spec_pops;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        dec_group_t g;
        dec_group_t h;
        int short_cycles;
        void'($urandom(58));
        @(posedge clk);
        while (rst) @(posedge clk);
        commit_en <= 1'b1;
        repeat (24) send_group(make_group(0));  // Long enough to wrap the ROB index
        repeat (10) send_group(make_group(1));
        repeat (8) begin
            g = make_group(2);
            send_group(g);
            h = make_group(0);
            h[0].rs1 = g[0].rd;  // Must see the younger writer of the pair
            send_group(h);
        end
        repeat (10) send_group(make_group(3));
        repeat (6) begin
            send_group(make_group(0));
            hold_output($urandom_range(1, 4));
        end
        commit_en <= 1'b0;
        short_cycles = 0;
        in_valid <= 1'b1;
        in_group <= make_group(0);
        while (short_cycles < 6) begin
            @(posedge clk);
            if (in_ready) begin
                in_group <= make_group(0);
            end else begin
                short_cycles++;
            end
        end
        commit_en <= 1'b1;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        in_valid <= 1'b0;
        // The first redirect round runs without commits and needs room for four groups
        while (fl_avail < 4 * rename_width) @(posedge clk);
        for (int k = 0; k < 2; k++) begin
            commit_en <= (k == 1);
            repeat (4) send_group(make_group(1));
            redirect <= 1'b1;
            @(posedge clk);
            redirect <= 1'b0;
            commit_en <= 1'b1;
            repeat (6) send_group(make_group(0));
        end
        repeat (4) @(posedge clk);
        for (int i = 0; i < 5; i++) begin
            if (reached[i] == 0) begin
                $display("Behavior never exercised: %s", behavior[i]);
                tb_errors++;
            end
        end
        $display("Errors: %0d assertion, %0d testbench", rename_stage_i.chk_i.fail_cnt, tb_errors);
        if (rename_stage_i.chk_i.fail_cnt + tb_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: flist.f
design/core_cfg_pkg.sv
design/rename_types_pkg.sv
design/rename_table.sv
design/free_list.sv
design/dep_check.sv
design/rename_stage.sv
bench/tb_clk_gen.sv
bench/rename_chk.sv
bench/rename_tb.sv

// File: Bender.yml
package:
  name: rename_stage

sources:
  - design/core_cfg_pkg.sv
  - design/rename_types_pkg.sv
  - design/rename_table.sv
  - design/free_list.sv
  - design/dep_check.sv
  - design/rename_stage.sv
  - target: simulation
    files:
      - bench/tb_clk_gen.sv
      - bench/rename_chk.sv
      - bench/rename_tb.sv
